/* cdb_consts.svh */
//##############################
// Widths and sizes shared by the CDB package and RTL
// Include wherever a port or constant needs them
//##############################
`ifndef CDB_CONSTS_SVH
`define CDB_CONSTS_SVH

// Datapath
`define CDB_DATA_W 32        // Result and address width
`define CDB_PC_STEP 4        // Sequential instruction increment

// Reorder buffer
`define CDB_ROB_W 3          // ROB tag width
`define CDB_ROB_DEPTH 8      // 2**CDB_ROB_W entries

// Branch outcome field {taken, mispredict, cond}
`define CDB_PCCTL_W 5
`define CDB_COND_W 3
`define CDB_PCCTL_TAKEN_BIT 4
`define CDB_PCCTL_MISP_BIT 3

`endif

/* cdbPkg.sv */
//##############################
// Types shared by the CDB units, arbiter and ROB table
//##############################
`include "cdb_consts.svh"

package cdbPkg;

  typedef logic [`CDB_DATA_W-1:0] dataT;     // Operand, result or address
  typedef logic [`CDB_ROB_W-1:0] robTagT;    // Reorder-buffer entry
  typedef logic [`CDB_PCCTL_W-1:0] pcCtlT;   // {taken, mispredict, cond}

  typedef enum logic [2:0] {
    ADD, SUB, AND, OR, XOR, SLL, SRL, SLT
  } aluOpT;

  // Encoding follows the usual funct3 layout
  typedef enum logic [`CDB_COND_W-1:0] {
    EQ  = 3'b000,
    NE  = 3'b001,
    LT  = 3'b100,
    GE  = 3'b101,
    LTU = 3'b110,
    GEU = 3'b111
  } brCondT;

  typedef enum logic [1:0] {Idle, Resolve, Request} brStateT;

  typedef struct packed {
    aluOpT op;
    dataT srcA;
    dataT srcB;
    robTagT robTag;
  } aluIssueT;

  typedef struct packed {
    brCondT cond;
    dataT srcA;
    dataT srcB;
    dataT pc;
    dataT offset;
    logic predictedTaken;
    robTagT robTag;
  } brIssueT;

  // What a unit offers the arbiter
  typedef struct packed {
    dataT result;
    robTagT robTag;
    dataT targetAddress;
    pcCtlT pcControl;
  } fuResultT;

  typedef struct packed {
    dataT result;
    robTagT robEntry;
    logic validBroadcast;
    dataT targetAddress;
    logic isControl;
    pcCtlT pcControl;
  } cdbBcastT;

endpackage

/* aluUnit.sv */
//##############################
// Single-cycle integer ALU with a result holding register
// Requests the CDB until the arbiter accepts the result
//##############################
`timescale 1ns/100ps
`include "cdb_consts.svh"

module aluUnit (
  input  logic              clk,
  input  logic              rstN,
  input  logic              aluIssueValid,
  input  cdbPkg::aluIssueT  aluIssue,
  input  logic              aluAvailable,
  output logic              aluReady,
  output logic              aluRequest,
  output cdbPkg::fuResultT  aluResult
);
  import cdbPkg::*;

  localparam int shamtW = $clog2(`CDB_DATA_W);

  dataT   aluOut;       // Combinational result of the issued op
  dataT   resultQ;      // Held until the bus takes it
  robTagT tagQ;
  logic   issueAccept;

  // Free when idle or when the pending result leaves this cycle
  assign aluReady    = ~aluRequest | aluAvailable;
  assign issueAccept = aluIssueValid & aluReady;

  always_comb begin
    aluOut = '0;
    case (aluIssue.op)
      ADD: aluOut = aluIssue.srcA + aluIssue.srcB;
      SUB: aluOut = aluIssue.srcA - aluIssue.srcB;
      AND: aluOut = aluIssue.srcA & aluIssue.srcB;
      OR:  aluOut = aluIssue.srcA | aluIssue.srcB;
      XOR: aluOut = aluIssue.srcA ^ aluIssue.srcB;
      SLL: aluOut = aluIssue.srcA << aluIssue.srcB[shamtW-1:0];
      SRL: aluOut = aluIssue.srcA >> aluIssue.srcB[shamtW-1:0];
      SLT: aluOut = dataT'($signed(aluIssue.srcA) < $signed(aluIssue.srcB));
      default: aluOut = '0;
    endcase
  end

  // Result and tag latch
  always_ff @(posedge clk) begin
    if (issueAccept) begin
      resultQ <= aluOut;
      tagQ    <= aluIssue.robTag;
    end
  end

  // Request level
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      aluRequest <= 1'b0;
    end else if (issueAccept) begin
      aluRequest <= 1'b1;                  // New result pending
    end else if (aluAvailable) begin
      aluRequest <= 1'b0;                  // Accepted, nothing behind it
    end
  end

  always_comb begin
    aluResult.result        = resultQ;
    aluResult.robTag        = tagQ;
    aluResult.targetAddress = '0;          // ALU never redirects
    aluResult.pcControl     = '0;
  end

endmodule

/* branchSeqFsm.sv */
//##############################
// Sequencer for the branch resolver
// Steps through operand capture, resolve and CDB request
//##############################
`timescale 1ns/100ps

module branchSeqFsm (
  input  logic clk,
  input  logic rstN,
  input  logic issueValid,
  input  logic available,
  output logic ready,
  output logic captureOperands,
  output logic captureResult,
  output logic request
);
  import cdbPkg::*;

  brStateT state;
  brStateT stateNext;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= Idle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext       = state;
    captureOperands = 1'b0;
    captureResult   = 1'b0;
    case (state)
      Idle: begin
        if (issueValid) begin
          stateNext       = Resolve;
          captureOperands = 1'b1;
        end
      end
      Resolve: begin
        stateNext     = Request;      // Condition settles in one cycle
        captureResult = 1'b1;
      end
      Request: begin
        if (available) begin
          if (issueValid) begin       // Back-to-back branch
            stateNext       = Resolve;
            captureOperands = 1'b1;
          end else begin
            stateNext = Idle;
          end
        end
      end
      default: stateNext = Idle;
    endcase
  end

  // Ready also while the held result is being taken
  assign ready   = (state == Idle) | ((state == Request) & available);
  assign request = (state == Request);

endmodule

/* branchUnit.sv */
//##############################
// Branch resolver: condition, target and pcControl
// Result is held until the CDB arbiter accepts it
//##############################
`timescale 1ns/100ps
`include "cdb_consts.svh"

module branchUnit (
  input  logic             clk,
  input  logic             rstN,
  input  logic             brIssueValid,
  input  cdbPkg::brIssueT  brIssue,
  input  logic             branchAvailable,
  output logic             brReady,
  output logic             branchRequest,
  output cdbPkg::fuResultT branchResult
);
  import cdbPkg::*;

  brIssueT  opQ;            // Registered operands
  fuResultT resQ;           // Held result
  logic     captureOperands;
  logic     captureResult;
  logic     taken;
  logic     mispredict;
  dataT     linkNext;
  dataT     targetNext;

  branchSeqFsm seq_i (
    .clk             (clk),
    .rstN            (rstN),
    .issueValid      (brIssueValid),
    .available       (branchAvailable),
    .ready           (brReady),
    .captureOperands (captureOperands),
    .captureResult   (captureResult),
    .request         (branchRequest)
  );

  always_ff @(posedge clk) begin
    if (captureOperands) opQ <= brIssue;
  end

  always_comb begin
    case (opQ.cond)
      EQ:      taken = (opQ.srcA == opQ.srcB);
      NE:      taken = (opQ.srcA != opQ.srcB);
      LT:      taken = ($signed(opQ.srcA) < $signed(opQ.srcB));
      GE:      taken = ($signed(opQ.srcA) >= $signed(opQ.srcB));
      LTU:     taken = (opQ.srcA < opQ.srcB);
      GEU:     taken = (opQ.srcA >= opQ.srcB);
      default: taken = 1'b0;     // Unused encodings fall through
    endcase
    mispredict = taken ^ opQ.predictedTaken;
    linkNext   = opQ.pc + dataT'(`CDB_PC_STEP);
    targetNext = taken ? (opQ.pc + opQ.offset) : linkNext;
  end

  always_ff @(posedge clk) begin
    if (captureResult) begin
      resQ.result        <= linkNext;            // Link value
      resQ.robTag        <= opQ.robTag;
      resQ.targetAddress <= targetNext;
      resQ.pcControl     <= {taken, mispredict, opQ.cond};
    end
  end

  assign branchResult = resQ;

endmodule

/* cdbArbiter.sv */
//##############################
// Round-robin common data bus arbiter
// Registers the winning result and reports unit availability
//##############################
`timescale 1ns/100ps

module cdbArbiter (
  input  logic             clk,
  input  logic             rstN,
  input  logic             aluRequest,
  input  logic             branchRequest,
  input  cdbPkg::fuResultT aluResult,
  input  cdbPkg::fuResultT branchResult,
  output logic             aluAvailable,
  output logic             branchAvailable,
  output cdbPkg::cdbBcastT cdbBus
);
  import cdbPkg::*;

  logic     pointer;        // 0 favours ALU, 1 favours branch
  logic     grantAlu;
  logic     grantBr;
  logic     anyRequest;
  fuResultT winner;

  // Broadcast registers
  logic   validQ;
  dataT   resultQ;
  robTagT robQ;
  dataT   targetQ;
  logic   isCtlQ;
  pcCtlT  pcCtlQ;

  always_comb begin
    grantAlu = 1'b0;
    grantBr  = 1'b0;
    if (!pointer) begin
      if (aluRequest)         grantAlu = 1'b1;
      else if (branchRequest) grantBr  = 1'b1;
    end else begin
      if (branchRequest)      grantBr  = 1'b1;
      else if (aluRequest)    grantAlu = 1'b1;
    end
  end

  assign anyRequest = aluRequest | branchRequest;
  assign winner     = grantBr ? branchResult : aluResult;

  // A unit is free if granted or idle
  assign aluAvailable    = grantAlu | ~aluRequest;
  assign branchAvailable = grantBr | ~branchRequest;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pointer <= 1'b0;
      validQ  <= 1'b0;
    end else begin
      validQ <= anyRequest;                 // One pulse per accepted result
      if (anyRequest) pointer <= grantAlu;  // Loser gets priority next
    end
  end

  always_ff @(posedge clk) begin
    if (anyRequest) begin
      resultQ <= winner.result;
      robQ    <= winner.robTag;
      isCtlQ  <= grantBr;
      pcCtlQ  <= winner.pcControl;
    end
    if (grantBr) targetQ <= branchResult.targetAddress;  // Only branches move it
  end

  always_comb begin
    cdbBus.result         = resultQ;
    cdbBus.robEntry       = robQ;
    cdbBus.validBroadcast = validQ;
    cdbBus.targetAddress  = targetQ;
    cdbBus.isControl      = isCtlQ;
    cdbBus.pcControl      = pcCtlQ;
  end

endmodule

/* robCompletionTable.sv */
//##############################
// Done bits per ROB entry, set from the CDB
// Raises a redirect on a mispredicted branch
//##############################
`timescale 1ns/100ps
`include "cdb_consts.svh"

module robCompletionTable (
  input  logic                       clk,
  input  logic                       rstN,
  input  cdbPkg::cdbBcastT           cdbBus,
  input  logic                       retireValid,
  input  cdbPkg::robTagT             retireTag,
  output logic [`CDB_ROB_DEPTH-1:0]  robDone,
  output logic                       redirectValid,
  output cdbPkg::dataT               redirectTarget
);

  logic mispredictHit;

  assign mispredictHit = cdbBus.validBroadcast & cdbBus.isControl
                       & cdbBus.pcControl[`CDB_PCCTL_MISP_BIT];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      robDone <= '0;
    end else begin
      if (retireValid) robDone[retireTag] <= 1'b0;
      // Later write wins when both name one entry
      if (cdbBus.validBroadcast) robDone[cdbBus.robEntry] <= 1'b1;
    end
  end

  // Redirect pulse
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      redirectValid <= 1'b0;
    end else begin
      redirectValid <= mispredictHit;
    end
  end

  always_ff @(posedge clk) begin
    if (mispredictHit) redirectTarget <= cdbBus.targetAddress;  // Resolved fetch address
  end

endmodule

/* cdbCore.sv */
//##############################
// Writeback corner top: ALU, branch unit, CDB arbiter, ROB table
//##############################
`timescale 1ns/100ps
`include "cdb_consts.svh"

module cdbCore (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       aluIssueValid,
  input  cdbPkg::aluIssueT           aluIssue,
  output logic                       aluReady,
  input  logic                       brIssueValid,
  input  cdbPkg::brIssueT            brIssue,
  output logic                       brReady,
  input  logic                       retireValid,
  input  cdbPkg::robTagT             retireTag,
  output cdbPkg::cdbBcastT           cdbBus,
  output logic [`CDB_ROB_DEPTH-1:0]  robDone,
  output logic                       redirectValid,
  output cdbPkg::dataT               redirectTarget
);
  import cdbPkg::*;

  logic     aluRequest;
  logic     branchRequest;
  logic     aluAvailable;
  logic     branchAvailable;
  fuResultT aluResult;
  fuResultT branchResult;

  aluUnit alu_i (
    .clk           (clk),
    .rstN          (rstN),
    .aluIssueValid (aluIssueValid),
    .aluIssue      (aluIssue),
    .aluAvailable  (aluAvailable),
    .aluReady      (aluReady),
    .aluRequest    (aluRequest),
    .aluResult     (aluResult)
  );

  branchUnit br_i (
    .clk             (clk),
    .rstN            (rstN),
    .brIssueValid    (brIssueValid),
    .brIssue         (brIssue),
    .branchAvailable (branchAvailable),
    .brReady         (brReady),
    .branchRequest   (branchRequest),
    .branchResult    (branchResult)
  );

  cdbArbiter arb_i (
    .clk             (clk),
    .rstN            (rstN),
    .aluRequest      (aluRequest),
    .branchRequest   (branchRequest),
    .aluResult       (aluResult),
    .branchResult    (branchResult),
    .aluAvailable    (aluAvailable),
    .branchAvailable (branchAvailable),
    .cdbBus          (cdbBus)
  );

  robCompletionTable rob_i (
    .clk            (clk),
    .rstN           (rstN),
    .cdbBus         (cdbBus),
    .retireValid    (retireValid),
    .retireTag      (retireTag),
    .robDone        (robDone),
    .redirectValid  (redirectValid),
    .redirectTarget (redirectTarget)
  );

endmodule

/* tb_cdbCore.sv */
//##############################
// Table-driven testbench for cdbCore
// Isolated latency, contention, done bits and redirects
//##############################
`timescale 1ns/100ps
`include "cdb_consts.svh"

module tb_cdbCore;
  import cdbPkg::*;

  typedef struct packed {
    logic isBr;
    aluOpT op;
    brCondT cond;
    dataT a;
    dataT b;
    dataT pc;
    dataT off;
    logic pred;
    dataT expResult;    // Expected broadcast fields
    dataT expTarget;
    pcCtlT expPcCtl;
  } rowT;

  logic clk, rstN, aluIssueValid, brIssueValid, retireValid;
  aluIssueT aluIssue;
  brIssueT brIssue;
  robTagT retireTag;
  logic aluReady, brReady, redirectValid;
  cdbBcastT bus;
  logic [`CDB_ROB_DEPTH-1:0] robDone;
  dataT redirectTarget;

  rowT rows[$];
  rowT pend[`CDB_ROB_DEPTH];
  logic [`CDB_ROB_DEPTH-1:0] pendValid;
  int acceptCycle[`CDB_ROB_DEPTH];
  int expLat[`CDB_ROB_DEPTH];          // Expected edges to broadcast or -1 to skip
  int errorCount = 0, checkCount = 0, cycleCount = 0;
  int bothReqCount = 0, redirectCount = 0, bcastCount = 0;
  logic latCheck = 1'b0;
  logic [31:0] seed = 32'hdd77;
  logic doneCheck = 1'b0, expRedir = 1'b0, grantCheck = 1'b0, expIsCtl = 1'b0, ptr = 1'b0;
  robTagT doneTag;
  dataT expRedirTgt;

  cdbCore dut_i (
    .clk(clk), .rstN(rstN),
    .aluIssueValid(aluIssueValid), .aluIssue(aluIssue), .aluReady(aluReady),
    .brIssueValid(brIssueValid), .brIssue(brIssue), .brReady(brReady),
    .retireValid(retireValid), .retireTag(retireTag), .cdbBus(bus),
    .robDone(robDone), .redirectValid(redirectValid), .redirectTarget(redirectTarget)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cycleCount <= cycleCount + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic dataT aluModel(aluOpT op, dataT a, dataT b);
    case (op)
      ADD: return a + b;
      SUB: return a - b;
      AND: return a & b;
      OR:  return a | b;
      XOR: return a ^ b;
      SLL: return a << b[4:0];
      SRL: return a >> b[4:0];
      default: return {31'd0, $signed(a) < $signed(b)};  // SLT
    endcase
  endfunction

  function automatic logic takenModel(brCondT c, dataT a, dataT b);
    case (c)
      EQ:  return a == b;
      NE:  return a != b;
      LT:  return $signed(a) < $signed(b);
      GE:  return $signed(a) >= $signed(b);
      LTU: return a < b;
      default: return a >= b;  // GEU
    endcase
  endfunction

  function automatic rowT makeAlu(aluOpT op, dataT a, dataT b);
    rowT r;
    r = '0;
    r.op = op;
    r.a = a;
    r.b = b;
    r.expResult = aluModel(op, a, b);
    return r;
  endfunction

  function automatic rowT makeBr(brCondT c, dataT a, dataT b, dataT pc, dataT off, logic pred);
    rowT r;
    logic t;
    r = '0;
    t = takenModel(c, a, b);
    r.isBr = 1'b1;
    r.cond = c;
    r.a = a;
    r.b = b;
    r.pc = pc;
    r.off = off;
    r.pred = pred;
    r.expResult = pc + `CDB_PC_STEP;                 // Link value
    r.expTarget = t ? pc + off : pc + `CDB_PC_STEP;
    r.expPcCtl  = {t, t ^ pred, c};
    return r;
  endfunction

  task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic failTimeout(string what);
    errorCount++;
    $display("Timeout while waiting for %s", what);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    $display("Simulation failed");
    $finish;
  endtask

  // Waits for a free tag and a ready unit, then issues one row
  task automatic issueRow(rowT r, robTagT tag);
    int n;
    n = 0;
    while (pendValid[tag] || !(r.isBr ? brReady : aluReady)) begin
      @(posedge clk);
      #2;
      n++;
      if (n > 200) failTimeout(r.isBr ? "brReady" : "aluReady");
    end
    pend[tag] = r;
    pendValid[tag] = 1'b1;
    expLat[tag] = latCheck ? (r.isBr ? 2 : 1) : -1;
    if (r.isBr) begin
      brIssue = '{cond: r.cond, srcA: r.a, srcB: r.b, pc: r.pc, offset: r.off,
                  predictedTaken: r.pred, robTag: tag};
      brIssueValid = 1'b1;
    end else begin
      aluIssue = '{op: r.op, srcA: r.a, srcB: r.b, robTag: tag};
      aluIssueValid = 1'b1;
    end
    @(posedge clk);
    #2;
    acceptCycle[tag] = cycleCount;
    if (r.isBr) brIssueValid = 1'b0;
    else aluIssueValid = 1'b0;
  endtask

  task automatic waitDrain();
    int n;
    n = 0;
    while (pendValid != '0) begin
      @(posedge clk);
      #2;
      n++;
      if (n > 500) failTimeout("outstanding broadcasts");
    end
  endtask

  // Bus monitor and pointer model sampling registered outputs mid-cycle
  always @(negedge clk) begin
    if (rstN) begin
      checkValue("redirectValid", redirectValid, expRedir);
      if (expRedir) begin
        checkValue("redirectTarget", redirectTarget, expRedirTgt);
        redirectCount++;
      end
      if (doneCheck) checkValue("robDone bit", robDone[doneTag], 1);
      doneCheck = 1'b0;
      expRedir = 1'b0;
      if (grantCheck) checkValue("cdbBus.isControl (grant order)", bus.isControl, expIsCtl);
      checkValue("cdbBus.validBroadcast", bus.validBroadcast, grantCheck);
      if (bus.validBroadcast) begin
        if (!pendValid[bus.robEntry]) begin
          errorCount++;
          $display("Broadcast of tag %0d that was not outstanding at %0t", bus.robEntry, $time);
        end else begin
          checkValue("cdbBus.result", bus.result, pend[bus.robEntry].expResult);
          checkValue("cdbBus.isControl", bus.isControl, pend[bus.robEntry].isBr);
          checkValue("cdbBus.pcControl", bus.pcControl, pend[bus.robEntry].expPcCtl);
          if (pend[bus.robEntry].isBr) begin
            checkValue("cdbBus.targetAddress", bus.targetAddress, pend[bus.robEntry].expTarget);
            expRedir = pend[bus.robEntry].expPcCtl[`CDB_PCCTL_MISP_BIT];
            expRedirTgt = pend[bus.robEntry].expTarget;
          end
          if (expLat[bus.robEntry] >= 0)
            checkValue("broadcast latency", cycleCount - acceptCycle[bus.robEntry],
                       expLat[bus.robEntry]);
          pendValid[bus.robEntry] = 1'b0;
          bcastCount++;
        end
        doneCheck = 1'b1;
        doneTag = bus.robEntry;
      end
      grantCheck = dut_i.aluRequest | dut_i.branchRequest;
      expIsCtl = (dut_i.aluRequest & dut_i.branchRequest) ? ptr : dut_i.branchRequest;
      if (dut_i.aluRequest & dut_i.branchRequest) begin
        bothReqCount++;
        checkValue("aluReady", aluReady, !expIsCtl);   // Loser holds, winner may reissue
        checkValue("brReady", brReady, expIsCtl);
      end
      if (grantCheck) ptr = ~expIsCtl;              // Loser gets priority next
    end
  end

  initial begin
    rowT aluQ[$];
    rowT brQ[$];
    brCondT conds[6];
    int aTag;
    int bTag;
    rstN = 1'b0;
    aluIssueValid = 1'b0;
    brIssueValid = 1'b0;
    retireValid = 1'b0;
    aluIssue = '0;
    brIssue = '0;
    retireTag = '0;
    pendValid = '0;
    conds = '{EQ, NE, LT, GE, LTU, GEU};
    // Directed rows cover every ALU op and every condition both ways
    for (int i = 0; i < 8; i++) begin
      rows.push_back(makeAlu(aluOpT'(i), 32'hf00f_1234, 32'h0000_0013));
    end
    rows.push_back(makeAlu(SLT, 32'hffff_fff0, 32'h5));
    for (int i = 0; i < 6; i++) begin
      rows.push_back(makeBr(conds[i], 32'h1, 32'hffff_ffff, 32'h1000 + 32*i, 32'h40, i[0]));
      rows.push_back(makeBr(conds[i], 32'hffff_ffff, 32'h1, 32'h1010 + 32*i,
                            32'hffff_ffe0, ~i[0]));
      rows.push_back(makeBr(conds[i], 32'h5, 32'h5, 32'h2000 + 32*i, 32'h80, 1'b1));
    end
    // Random rows for the contention phase
    for (int i = 0; i < 12; i++) begin
      seed = xorshift(seed);
      aluQ.push_back(makeAlu(aluOpT'(seed[2:0]), seed, xorshift(seed)));
      seed = xorshift(seed);
      brQ.push_back(makeBr(conds[seed[31:28] % 6], seed[7:0], seed[15:8],
                           {seed[27:18], 2'b00}, {seed[19:12], 2'b00}, seed[0]));
    end
    repeat (8) @(posedge clk);
    #2;
    rstN = 1'b1;
    @(negedge clk);
    checkValue("cdbBus.validBroadcast", bus.validBroadcast, 0);
    checkValue("redirectValid", redirectValid, 0);
    checkValue("robDone", robDone, 0);
    checkValue("aluReady", aluReady, 1);
    checkValue("brReady", brReady, 1);
    @(posedge clk);
    #2;
    aTag = 0;
    bTag = 4;
    latCheck = 1'b1;
    foreach (rows[i]) begin
      if (rows[i].isBr) begin
        issueRow(rows[i], robTagT'(4 + bTag % 4));
        bTag++;
      end else begin
        issueRow(rows[i], robTagT'(aTag % 4));
        aTag++;
      end
      waitDrain();
      repeat (2) @(posedge clk);
      #2;
    end
    latCheck = 1'b0;
    fork
      foreach (aluQ[i]) issueRow(aluQ[i], robTagT'(i % 4));
      foreach (brQ[i]) issueRow(brQ[i], robTagT'(4 + i % 4));
    join
    waitDrain();
    repeat (2) @(posedge clk);
    #2;
    // Retire every entry and expect its done bit to clear
    for (int t = 0; t < `CDB_ROB_DEPTH; t++) begin
      retireValid = 1'b1;
      retireTag = robTagT'(t);
      @(posedge clk);
      #2;
      retireValid = 1'b0;
      checkValue("robDone after retire", robDone[t], 0);
    end
    checkValue("broadcast count", bcastCount, rows.size() + aluQ.size() + brQ.size());
    if (bothReqCount == 0 || redirectCount == 0) begin
      errorCount++;
      $display("Contention or redirect was never exercised");
    end
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+.
cdbPkg.sv
aluUnit.sv
branchSeqFsm.sv
branchUnit.sv
cdbArbiter.sv
robCompletionTable.sv
cdbCore.sv
tb_cdbCore.sv
